// File: include/dmem_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizing constants for the data memory
// include wherever address or lane widths are needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DMEM_CONSTS_SVH
`define DMEM_CONSTS_SVH

// byte address width, 4 KiB of data memory
`define DMEM_ADDR_W 12
// doublewords in the array, 2**(ADDR_W-3)
`define DMEM_DEPTH 512
// one doubleword per array entry
`define DMEM_DATA_W 64
// byte lanes in one doubleword
`define DMEM_LANES 8

`endif

// File: verilog/dmem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the data memory subsystem
// referenced by scoped name from the RTL and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dmem_pkg;

    // access size, encoded as funct3[1:0] of the RV64 load/store
    typedef enum logic [1:0] {
        SZ_B = 2'b00,
        SZ_H = 2'b01,
        SZ_W = 2'b10,
        SZ_D = 2'b11
    } size_e;

    // one doubleword of payload
    typedef logic [63:0] dword_t;

    // per-lane write enable
    // bit k covers bits 8k+7 down to 8k
    typedef logic [7:0] bmask_t;

endpackage

// File: verilog/mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// doubleword storage array
// byte-masked write and registered read
// both ports freeze while hold_i is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dmem_consts.svh"

module mem (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    hold_i,
    input  logic                    wen_i,
    input  logic [`DMEM_ADDR_W-4:0] waddr_i,
    input  dmem_pkg::dword_t        wdata_i,
    input  dmem_pkg::bmask_t        wmask_i,
    input  logic                    ren_i,
    input  logic [`DMEM_ADDR_W-4:0] raddr_i,
    output dmem_pkg::dword_t        rdata_o
);

    // storage itself, contents survive reset
    dmem_pkg::dword_t mem_q [0:`DMEM_DEPTH-1];

    logic wr_acc;
    logic rd_acc;

    // no access while in reset or held
    assign wr_acc = wen_i && !hold_i && !reset_i;
    assign rd_acc = ren_i && !hold_i && !reset_i;

    // write only the enabled lanes
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            for (int k = 0; k < `DMEM_LANES; k++) begin
                if (wmask_i[k]) begin
                    mem_q[waddr_i][8*k +: 8] <= wdata_i[8*k +: 8];
                end
            end
        end
    end

    // read register keeps its value between accepted reads
    // a same-index write in the same cycle is not seen here
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

// File: verilog/ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data RAM with read/write collision handling
// wraps mem and merges same-cycle store bytes
// into the read data one cycle later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dmem_consts.svh"

module ram (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    hold_i,
    input  logic                    wen_i,
    input  logic [`DMEM_ADDR_W-4:0] waddr_i,
    input  dmem_pkg::dword_t        wdata_i,
    input  dmem_pkg::bmask_t        wmask_i,
    input  logic                    ren_i,
    input  logic [`DMEM_ADDR_W-4:0] raddr_i,
    output dmem_pkg::dword_t        rdata_o
);

    localparam int LANE_W = `DMEM_DATA_W / `DMEM_LANES;

    dmem_pkg::dword_t mem_rdata;

    // collision state, captured with the read
    logic             fwd_q;
    dmem_pkg::bmask_t fmask_q;
    dmem_pkg::dword_t fdata_q;

    mem u_mem (
        .clk     (clk),
        .reset_i (reset_i),
        .hold_i  (hold_i),
        .wen_i   (wen_i),
        .waddr_i (waddr_i),
        .wdata_i (wdata_i),
        .wmask_i (wmask_i),
        .ren_i   (ren_i),
        .raddr_i (raddr_i),
        .rdata_o (mem_rdata)
    );

    // flag a read and a write hitting the same doubleword
    // held along with the mem read register under hold
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fwd_q <= 1'b0;
        end else if (!hold_i) begin
            fwd_q <= ren_i && wen_i && (raddr_i == waddr_i);
        end
    end

    // store bytes to lay over the old read data
    always_ff @(posedge clk) begin
        if (!hold_i) begin
            fmask_q <= wmask_i;
            fdata_q <= wdata_i;
        end
    end

    // byte-wise merge, new lanes win over stale array data
    always_comb begin
        rdata_o = mem_rdata;
        for (int k = 0; k < `DMEM_LANES; k++) begin
            if (fwd_q && fmask_q[k]) begin
                rdata_o[LANE_W*k +: LANE_W] = fdata_q[LANE_W*k +: LANE_W];
            end
        end
    end

endmodule

// File: verilog/store_align.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store lane alignment
// builds the byte mask and moves store data
// up to its lanes, purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dmem_consts.svh"

module store_align (
    input  logic [2:0]          store_addr_lo_i,
    input  dmem_pkg::size_e     store_size_i,
    input  dmem_pkg::dword_t    store_data_i,
    output dmem_pkg::bmask_t    wmask_o,
    output dmem_pkg::dword_t    wdata_o
);

    // lane run before shifting to the offset
    logic [`DMEM_LANES-1:0] base_mask;
    logic [5:0]             bit_shift;

    always_comb begin
        case (store_size_i)
            dmem_pkg::SZ_B: base_mask = 8'h01;
            dmem_pkg::SZ_H: base_mask = 8'h03;
            dmem_pkg::SZ_W: base_mask = 8'h0f;
            default:        base_mask = 8'hff;
        endcase
    end

    // byte offset in bits
    assign bit_shift = {store_addr_lo_i, 3'b000};

    // aligned accesses keep the run inside the doubleword
    assign wmask_o = base_mask << store_addr_lo_i;

    // low bytes of the source land at the offset lanes
    // bytes above the run are masked off by wmask_o
    assign wdata_o = store_data_i << bit_shift;

endmodule

// File: verilog/load_extract.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load byte selection and extension
// captures load controls alongside the RAM read,
// then registers the extended result and valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module load_extract (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                hold_i,
    input  logic                load_en_i,
    input  logic [2:0]          load_addr_lo_i,
    input  dmem_pkg::size_e     load_size_i,
    input  logic                load_unsigned_i,
    input  dmem_pkg::dword_t    rdata_i,
    output dmem_pkg::dword_t    load_data_o,
    output logic                load_valid_o
);

    // controls of the read now in flight
    logic [2:0]       off_q;
    dmem_pkg::size_e  size_q;
    logic             uns_q;
    logic             pend_q;

    dmem_pkg::dword_t shifted;
    dmem_pkg::dword_t ext_data;

    // pending bit marks a read issued at the last accepted edge
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pend_q <= 1'b0;
        end else if (!hold_i) begin
            pend_q <= load_en_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i && load_en_i) begin
            off_q  <= load_addr_lo_i;
            size_q <= load_size_i;
            uns_q  <= load_unsigned_i;
        end
    end

    // bring the addressed byte down to lane 0
    assign shifted = rdata_i >> {off_q, 3'b000};

    // keep the size's bytes and fill above
    always_comb begin
        case (size_q)
            dmem_pkg::SZ_B: ext_data = {{56{!uns_q && shifted[7]}}, shifted[7:0]};
            dmem_pkg::SZ_H: ext_data = {{48{!uns_q && shifted[15]}}, shifted[15:0]};
            dmem_pkg::SZ_W: ext_data = {{32{!uns_q && shifted[31]}}, shifted[31:0]};
            default:        ext_data = shifted;
        endcase
    end

    // result only moves on a completing load
    // valid drops on the next accepted cycle without one
    always_ff @(posedge clk) begin
        if (reset_i) begin
            load_valid_o <= 1'b0;
            load_data_o  <= '0;
        end else if (!hold_i) begin
            load_valid_o <= pend_q;
            if (pend_q) begin
                load_data_o <= ext_data;
            end
        end
    end

endmodule

// File: verilog/dmem_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data memory subsystem top level
// store port from execute, load port from decode
// connects store_align, ram and load_extract
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dmem_consts.svh"

module dmem_top (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    hold_i,
    // store port
    input  logic                    store_en_i,
    input  logic [`DMEM_ADDR_W-1:0] store_addr_i,
    input  dmem_pkg::dword_t        store_data_i,
    input  dmem_pkg::size_e         store_size_i,
    // load port
    input  logic                    load_en_i,
    input  logic [`DMEM_ADDR_W-1:0] load_addr_i,
    input  dmem_pkg::size_e         load_size_i,
    input  logic                    load_unsigned_i,
    output dmem_pkg::dword_t        load_data_o,
    output logic                    load_valid_o
);

    dmem_pkg::bmask_t st_mask;
    dmem_pkg::dword_t st_data;
    dmem_pkg::dword_t rd_data;

    // byte offset picks lanes for the store
    store_align u_store_align (
        .store_addr_lo_i (store_addr_i[2:0]),
        .store_size_i    (store_size_i),
        .store_data_i    (store_data_i),
        .wmask_o         (st_mask),
        .wdata_o         (st_data)
    );

    // array is indexed by doubleword
    ram u_ram (
        .clk     (clk),
        .reset_i (reset_i),
        .hold_i  (hold_i),
        .wen_i   (store_en_i),
        .waddr_i (store_addr_i[`DMEM_ADDR_W-1:3]),
        .wdata_i (st_data),
        .wmask_i (st_mask),
        .ren_i   (load_en_i),
        .raddr_i (load_addr_i[`DMEM_ADDR_W-1:3]),
        .rdata_o (rd_data)
    );

    load_extract u_load_extract (
        .clk             (clk),
        .reset_i         (reset_i),
        .hold_i          (hold_i),
        .load_en_i       (load_en_i),
        .load_addr_lo_i  (load_addr_i[2:0]),
        .load_size_i     (load_size_i),
        .load_unsigned_i (load_unsigned_i),
        .rdata_i         (rd_data),
        .load_data_o     (load_data_o),
        .load_valid_o    (load_valid_o)
    );

endmodule

// File: verif/dmem_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol checks on the data memory top level
// bound to dmem_top, reports via failing assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dmem_consts.svh"

module dmem_assert (
    input logic                    clk,
    input logic                    reset_i,
    input logic                    hold_i,
    input logic                    store_en_i,
    input logic [`DMEM_ADDR_W-1:0] store_addr_i,
    input dmem_pkg::size_e         store_size_i,
    input logic                    load_en_i,
    input logic [`DMEM_ADDR_W-1:0] load_addr_i,
    input dmem_pkg::size_e         load_size_i,
    input dmem_pkg::dword_t        load_data_o,
    input logic                    load_valid_o
);

    // offset bits that must be zero for a size
    function automatic logic [2:0] low_bits(input dmem_pkg::size_e sz);
        return 3'((1 << sz) - 1);
    endfunction

    store_aligned: assert property (@(posedge clk) disable iff (reset_i)
        store_en_i |-> (store_addr_i[2:0] & low_bits(store_size_i)) == 3'b000)
        else $error("misaligned store at address %h", store_addr_i);

    load_aligned: assert property (@(posedge clk) disable iff (reset_i)
        load_en_i |-> (load_addr_i[2:0] & low_bits(load_size_i)) == 3'b000)
        else $error("misaligned load at address %h", load_addr_i);

    // result shows up after the next edge that is not held
    valid_after_load: assert property (@(posedge clk) disable iff (reset_i)
        (load_en_i && !hold_i) ##1 !hold_i |=> load_valid_o)
        else $error("load_valid_o not raised one cycle after an accepted load");

    // held edge must not move the outputs
    stable_on_hold: assert property (@(posedge clk) disable iff (reset_i)
        hold_i |=> $stable(load_data_o) && $stable(load_valid_o))
        else $error("load outputs changed during hold");

endmodule

bind dmem_top dmem_assert u_dmem_assert (.*);

// File: verif/dmem_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the data memory subsystem
// directed and random store/load traffic,
// checked against a doubleword model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "dmem_consts.svh"

module dmem_tb;

    localparam int USED_DW  = 16;
    localparam int RAND_OPS = 300;
    // reset, idle, fill, lane stores, sweep, collisions, hold, random, drain
    localparam int PLAN_CYC = 3 + 8 + 2*USED_DW + 56 + 30 + USED_DW + 14 + RAND_OPS + 8;
    localparam int TIMEOUT_CYC = 4 * PLAN_CYC;

    logic                    clk;
    logic                    reset_i;
    logic                    hold_i;
    logic                    store_en_i;
    logic [`DMEM_ADDR_W-1:0] store_addr_i;
    dmem_pkg::dword_t        store_data_i;
    dmem_pkg::size_e         store_size_i;
    logic                    load_en_i;
    logic [`DMEM_ADDR_W-1:0] load_addr_i;
    dmem_pkg::size_e         load_size_i;
    logic                    load_unsigned_i;
    dmem_pkg::dword_t        load_data_o;
    logic                    load_valid_o;

    integer           seed;
    dmem_pkg::dword_t model [0:`DMEM_DEPTH-1];
    // expected results of accepted loads in issue order
    dmem_pkg::dword_t exp_q [$];

    dmem_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic string mismatch_line(input string name, input dmem_pkg::dword_t exp,
                                            input dmem_pkg::dword_t got);
        return $sformatf("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
    endfunction

    // expected load value from the size rules of RV64 loads
    function automatic dmem_pkg::dword_t ref_load(input dmem_pkg::dword_t dw,
                                                  input logic [2:0] off,
                                                  input dmem_pkg::size_e sz, input logic uns);
        int               nbytes;
        logic             sign;
        dmem_pkg::dword_t val;
        nbytes = 1 << sz;
        sign = !uns && dw[8*(off+nbytes)-1];
        for (int i = 0; i < 8; i++) begin
            val[8*i +: 8] = (i < nbytes) ? dw[8*(off+i) +: 8] : {8{sign}};
        end
        return val;
    endfunction

    task automatic model_store(input logic [`DMEM_ADDR_W-1:0] addr, input dmem_pkg::dword_t data,
                               input dmem_pkg::size_e sz);
        for (int i = 0; i < (1 << sz); i++) begin
            model[addr[`DMEM_ADDR_W-1:3]][8*(addr[2:0]+i) +: 8] = data[8*i +: 8];
        end
    endtask

    // one cycle of traffic with the model updated only when not held
    task automatic drive_cycle(input logic st_en, input logic [`DMEM_ADDR_W-1:0] st_addr,
                               input dmem_pkg::dword_t st_data, input dmem_pkg::size_e st_size,
                               input logic ld_en, input logic [`DMEM_ADDR_W-1:0] ld_addr,
                               input dmem_pkg::size_e ld_size, input logic ld_uns,
                               input logic hold);
        @(posedge clk);
        hold_i          <= hold;
        store_en_i      <= st_en;
        store_addr_i    <= st_addr;
        store_data_i    <= st_data;
        store_size_i    <= st_size;
        load_en_i       <= ld_en;
        load_addr_i     <= ld_addr;
        load_size_i     <= ld_size;
        load_unsigned_i <= ld_uns;
        if (!hold) begin
            // store first so a same-cycle load sees the new bytes
            if (st_en) begin
                model_store(st_addr, st_data, st_size);
            end
            if (ld_en) begin
                exp_q.push_back(ref_load(model[ld_addr[`DMEM_ADDR_W-1:3]], ld_addr[2:0],
                                         ld_size, ld_uns));
            end
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, '0, dmem_pkg::SZ_B, 1'b0, '0, dmem_pkg::SZ_B, 1'b0, 1'b0);
    endtask

    task automatic store_op(input logic [`DMEM_ADDR_W-1:0] a, input dmem_pkg::dword_t d,
                            input dmem_pkg::size_e sz);
        drive_cycle(1'b1, a, d, sz, 1'b0, '0, dmem_pkg::SZ_B, 1'b0, 1'b0);
    endtask

    task automatic load_op(input logic [`DMEM_ADDR_W-1:0] a, input dmem_pkg::size_e sz,
                           input logic uns);
        drive_cycle(1'b0, '0, '0, dmem_pkg::SZ_B, 1'b1, a, sz, uns, 1'b0);
    endtask

    function automatic dmem_pkg::dword_t random_dword();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic dmem_pkg::size_e pick_size();
        logic [31:0] r;
        r = $random(seed);
        return dmem_pkg::size_e'(r[1:0]);
    endfunction

    // random address in the filled doublewords aligned to sz
    function automatic logic [`DMEM_ADDR_W-1:0] aligned_addr(input dmem_pkg::size_e sz);
        logic [31:0]             r;
        logic [`DMEM_ADDR_W-1:0] a;
        r = $random(seed);
        a = '0;
        a[6:0] = r[6:0];
        a[2:0] = (a[2:0] >> sz) << sz;
        return a;
    endfunction

    initial begin : stimulus
        int                      k;
        logic [31:0]             r;
        dmem_pkg::size_e         szs;
        dmem_pkg::size_e         szl;
        dmem_pkg::dword_t        d;
        logic [`DMEM_ADDR_W-1:0] sa;
        logic [`DMEM_ADDR_W-1:0] la;
        seed = 32'h5bd7_2439;
        reset_i = 1'b1;
        hold_i = 1'b0;
        store_en_i = 1'b0;
        store_addr_i = '0;
        store_data_i = '0;
        store_size_i = dmem_pkg::SZ_B;
        load_en_i = 1'b0;
        load_addr_i = '0;
        load_size_i = dmem_pkg::SZ_B;
        load_unsigned_i = 1'b0;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        // quiet after reset with valid held low
        repeat (8) idle_cycle();
        // fill every used doubleword and read it straight back
        for (int i = 0; i < USED_DW; i++) begin
            store_op(12'(i*8), random_dword(), dmem_pkg::SZ_D);
            load_op(12'(i*8), dmem_pkg::SZ_D, 1'b0);
        end
        // partial stores at each aligned offset of doubleword 1
        k = 0;
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 8; off += (1 << s)) begin
                d = random_dword();
                // alternate the sign bit of the stored value
                d[(8 << s) - 1] = k[0];
                store_op(12'(8 + off), d, dmem_pkg::size_e'(s));
                load_op(12'(8 + off), dmem_pkg::size_e'(s), 1'b0);
                load_op(12'(8 + off), dmem_pkg::size_e'(s), 1'b1);
                load_op(12'd8, dmem_pkg::SZ_D, 1'b0);
                k++;
            end
        end
        // every size, offset and sign mode over the mixed doubleword
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off += (1 << s)) begin
                load_op(12'(8 + off), dmem_pkg::size_e'(s), 1'b0);
                load_op(12'(8 + off), dmem_pkg::size_e'(s), 1'b1);
            end
        end
        // same-cycle store and load in one doubleword
        for (int i = 0; i < USED_DW; i++) begin
            r = $random(seed);
            szs = pick_size();
            szl = pick_size();
            sa = aligned_addr(szs);
            la = aligned_addr(szl);
            la[`DMEM_ADDR_W-1:3] = sa[`DMEM_ADDR_W-1:3];
            drive_cycle(1'b1, sa, random_dword(), szs, 1'b1, la, szl, r[0], 1'b0);
        end
        // held traffic is dropped and the outputs freeze
        load_op(12'd16, dmem_pkg::SZ_D, 1'b0);
        repeat (4) drive_cycle(1'b1, 12'd16, '1, dmem_pkg::SZ_D, 1'b1, 12'd20,
                               dmem_pkg::SZ_W, 1'b0, 1'b1);
        load_op(12'd16, dmem_pkg::SZ_D, 1'b0);
        load_op(12'd20, dmem_pkg::SZ_W, 1'b0);
        load_op(12'd24, dmem_pkg::SZ_H, 1'b0);
        repeat (2) drive_cycle(1'b0, '0, '0, dmem_pkg::SZ_B, 1'b0, '0, dmem_pkg::SZ_B, 1'b0, 1'b1);
        load_op(12'd28, dmem_pkg::SZ_W, 1'b1);
        // random mix with back-to-back loads
        for (int n = 0; n < RAND_OPS; n++) begin
            r = $random(seed);
            szs = pick_size();
            szl = pick_size();
            sa = aligned_addr(szs);
            la = aligned_addr(szl);
            drive_cycle(r[0], sa, random_dword(), szs, r[1] | r[2], la, szl, r[3],
                        r[6:4] == 3'b000);
        end
        // last result lands one cycle after its load is taken
        repeat (4) idle_cycle();
        if (exp_q.size() != 0) begin
            report_fail("expected load results left over at end of run");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

    // inputs sampled at the edge and outputs checked at the following negedge
    initial begin : compare
        logic             rst_seen;
        logic             acc;
        logic             ld_seen;
        logic             pend;
        logic             prev_valid;
        dmem_pkg::dword_t prev_data;
        dmem_pkg::dword_t exp_val;
        pend = 1'b0;
        prev_valid = 1'b0;
        prev_data = '0;
        forever begin
            @(posedge clk);
            rst_seen = reset_i;
            acc = !reset_i && !hold_i;
            ld_seen = load_en_i;
            @(negedge clk);
            if (rst_seen) begin
                pend = 1'b0;
                assert (load_valid_o === 1'b0)
                    else report_fail(mismatch_line("load_valid_o", 0, load_valid_o));
                assert (load_data_o === '0)
                    else report_fail(mismatch_line("load_data_o", '0, load_data_o));
            end else if (acc) begin
                assert (load_valid_o === pend)
                    else report_fail(mismatch_line("load_valid_o", pend, load_valid_o));
                if (pend) begin
                    assert (exp_q.size() > 0)
                        else report_fail("load result arrived with no load outstanding");
                    exp_val = exp_q.pop_front();
                    assert (load_data_o === exp_val)
                        else report_fail(mismatch_line("load_data_o", exp_val, load_data_o));
                end
                pend = ld_seen;
            end else begin
                assert (load_valid_o === prev_valid)
                    else report_fail(mismatch_line("load_valid_o", prev_valid, load_valid_o));
                assert (load_data_o === prev_data)
                    else report_fail(mismatch_line("load_data_o", prev_data, load_data_o));
            end
            prev_valid = load_valid_o;
            prev_data = load_data_o;
        end
    end

    initial begin : watchdog
        int cycle_cnt;
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYC) begin
            @(posedge clk);
            cycle_cnt++;
        end
        report_fail($sformatf("timeout after %0d cycles, loads never completed", TIMEOUT_CYC));
    end

endmodule

// File: src.f
+incdir+include
verilog/dmem_pkg.sv
verilog/mem.sv
verilog/ram.sv
verilog/store_align.sv
verilog/load_extract.sv
verilog/dmem_top.sv
verif/dmem_assert.sv
verif/dmem_tb.sv
